// File: files.f
bru_pkg.sv
bru_decode.sv
ex_bru.sv
bru_execute.sv
bru_result.sv
bru_top.sv
tb_bru_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the branch path testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_bru_top
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module "$TOP" -Mdir obj_dir -f files.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/V"$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "TESTS FAILED" "$SIM_LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

exit 0

// File: bru_stim.txt
// Branch path stimulus, one instruction per line, all values hex
// insn pc operand1 operand2 br_valid br_taken br_tgt lnk_we lnk_data align_fault
// Record count
1e
// BEQ and BNE, offset +0x10
00200001 00000100 00000005 00000005 1 1 00000110 0 00000404 0
00200001 00000101 00000005 00000006 1 0 00000000 0 00000408 0
00200002 00000102 00000005 00000006 1 1 00000112 0 0000040c 0
00200002 00000103 00000007 00000007 1 0 00000000 0 00000410 0
// BGTU, last one is -1 against 1
00200003 00000104 00000009 00000003 1 1 00000114 0 00000414 0
00200003 00000105 00000003 00000003 1 0 00000000 0 00000418 0
00200003 00000106 ffffffff 00000001 1 1 00000116 0 0000041c 0
// BGT, signed disagreement and overflow corners
00200004 00000107 ffffffff 00000001 1 0 00000000 0 00000420 0
00200004 00000108 00000001 ffffffff 1 1 00000118 0 00000424 0
00200004 00000109 80000000 00000001 1 0 00000000 0 00000428 0
00200004 0000010a 00000001 80000000 1 1 0000011a 0 0000042c 0
// BLEU
00200005 0000010b 00000003 00000009 1 1 0000011b 0 00000430 0
00200005 0000010c ffffffff 00000001 1 0 00000000 0 00000434 0
00200005 0000010d 00000004 00000004 1 1 0000011d 0 00000438 0
// BLE
00200006 0000010e ffffffff 00000001 1 1 0000011e 0 0000043c 0
00200006 0000010f 80000000 00000001 1 1 0000011f 0 00000440 0
00200006 00000110 00000005 00000002 1 0 00000000 0 00000444 0
// BEQ with offset -4
fff80001 00000200 00000000 00000000 1 1 000001fc 0 00000804 0
// BNE with link bit, no link for conditional
00200012 00000201 00000001 00000002 1 1 00000211 0 00000808 0
// JMPREL through operand2, without and with link
00000007 00000300 12345678 00000040 1 1 00000310 0 00000c04 0
00000017 00000302 00000000 fffffff0 1 1 000002fe 1 00000c0c 0
// JMPREG through operand1, without and with link
00000008 00000304 00001000 00000000 1 1 00000400 0 00000c14 0
00000018 00000305 00002008 00000000 1 1 00000802 1 00000c18 0
// JMPREG misaligned, fault
00000018 00000306 00001002 00000000 1 0 00000000 0 00000c1c 1
00000008 00000307 00001001 00000000 1 0 00000000 0 00000c20 1
// Non-branch opcodes
00200010 00000400 00000000 00000000 0 0 00000000 0 00001004 0
0000001f 00000401 00001002 00000000 0 0 00000000 0 00001008 0
00000009 00000402 00000003 00000003 0 0 00000000 0 0000100c 0
// Branches after non-branch
00200001 00000500 00000000 00000000 1 1 00000510 0 00001404 0
00000018 00000501 00000000 00000000 1 1 00000000 1 00001408 0

// File: tb_bru_top.sv
// Testbench for the branch path, file driven with a 3 cycle expected-value pipe
`timescale 1ns/1ns

module tb_bru_top;

   localparam int CONFIG_DW = 32;
   localparam int CONFIG_AW = 32;
   localparam int PC_W = CONFIG_AW - bru_pkg::P_INSN_LEN;
   // Words per stimulus record
   localparam int REC_W = 10;
   localparam int MAX_REC = 64;
   localparam int LATENCY = 3;

   typedef struct packed {
      logic                 br_valid;
      logic                 br_taken;
      logic [PC_W-1:0]      br_tgt;
      logic                 lnk_we;
      logic [CONFIG_DW-1:0] lnk_data;
      logic                 align_fault;
      int                   line;
      int                   due;
   } exp_t;

   logic                 clk;
   logic                 rst_n;
   logic                 in_valid;
   bru_pkg::insn_t       in_insn;
   logic [PC_W-1:0]      in_pc;
   logic [CONFIG_DW-1:0] in_operand1;
   logic [CONFIG_DW-1:0] in_operand2;
   logic                 br_valid;
   logic                 br_taken;
   logic [PC_W-1:0]      br_tgt;
   logic                 lnk_we;
   logic [CONFIG_DW-1:0] lnk_data;
   logic                 align_fault;

   // Word 0 is the record count, then REC_W words per record
   logic [31:0] stim_mem [0:REC_W*MAX_REC];
   exp_t        exp_q [$];
   int          cyc = 0;
   int          timeout_limit = 10000;

   bru_top #(
      .CONFIG_DW (CONFIG_DW),
      .CONFIG_AW (CONFIG_AW)
   ) i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_insn     (in_insn),
      .in_pc       (in_pc),
      .in_operand1 (in_operand1),
      .in_operand2 (in_operand2),
      .br_valid    (br_valid),
      .br_taken    (br_taken),
      .br_tgt      (br_tgt),
      .lnk_we      (lnk_we),
      .lnk_data    (lnk_data),
      .align_fault (align_fault)
   );

   // 20 ns period
   always #10 clk = ~clk;

   // Cycle count and run limit
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= timeout_limit) begin
         $display("Timeout after %0d cycles with %0d results outstanding", cyc, exp_q.size());
         $display("TESTS FAILED");
         $fatal(1, "run limit reached");
      end
   end

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic stop_on_failure();
      $display("TESTS FAILED");
      $fatal(1, "first mismatch, run stopped");
   endtask

   task automatic check_flag(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         $display("Fail %s expected %0b actual %0b", name, exp_v, act_v);
         stop_on_failure();
      end
   endtask

   task automatic check_pc(input string name, input logic [PC_W-1:0] exp_v,
                           input logic [PC_W-1:0] act_v);
      if (act_v !== exp_v) begin
         $display("Fail %s expected %h actual %h", name, exp_v, act_v);
         stop_on_failure();
      end
   endtask

   task automatic check_data(input string name, input logic [CONFIG_DW-1:0] exp_v,
                             input logic [CONFIG_DW-1:0] act_v);
      if (act_v !== exp_v) begin
         $display("Fail %s expected %h actual %h", name, exp_v, act_v);
         stop_on_failure();
      end
   endtask

   // Outputs are stable at the falling edge
   task automatic check_outputs();
      exp_t  e;
      string tag;
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
         e = exp_q.pop_front();
         tag = $sformatf("line %0d", e.line);
         check_flag({tag, " br_valid"}, e.br_valid, br_valid);
         check_flag({tag, " br_taken"}, e.br_taken, br_taken);
         check_pc({tag, " br_tgt"}, e.br_tgt, br_tgt);
         check_flag({tag, " lnk_we"}, e.lnk_we, lnk_we);
         check_data({tag, " lnk_data"}, e.lnk_data, lnk_data);
         check_flag({tag, " align_fault"}, e.align_fault, align_fault);
      end else begin
         // Nothing due, all strobes quiet
         tag = $sformatf("idle cycle %0d", cyc);
         check_flag({tag, " br_valid"}, 1'b0, br_valid);
         check_flag({tag, " br_taken"}, 1'b0, br_taken);
         check_flag({tag, " lnk_we"}, 1'b0, lnk_we);
         check_flag({tag, " align_fault"}, 1'b0, align_fault);
      end
   endtask

   task automatic drive_idle();
      in_valid = 1'b0;
      in_insn = '0;
   endtask

   // Apply one record and queue its expected result
   task automatic drive_line(input int idx);
      exp_t e;
      int   base;
      base = 1 + idx * REC_W;
      in_valid = 1'b1;
      in_insn = stim_mem[base];
      in_pc = stim_mem[base+1][PC_W-1:0];
      in_operand1 = stim_mem[base+2];
      in_operand2 = stim_mem[base+3];
      e.br_valid = stim_mem[base+4][0];
      e.br_taken = stim_mem[base+5][0];
      e.br_tgt = stim_mem[base+6][PC_W-1:0];
      e.lnk_we = stim_mem[base+7][0];
      e.lnk_data = stim_mem[base+8];
      e.align_fault = stim_mem[base+9][0];
      e.line = idx + 1;
      e.due = cyc + LATENCY;
      exp_q.push_back(e);
   endtask

   initial begin
      int          n_rec;
      logic [31:0] lfsr;
      clk = 1'b0;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_insn = '0;
      in_pc = '0;
      in_operand1 = '0;
      in_operand2 = '0;
      lfsr = 32'h628012aa;

      $readmemh("bru_stim.txt", stim_mem);
      n_rec = stim_mem[0];
      if (n_rec <= 0 || n_rec > MAX_REC) begin
         $display("Stimulus file bru_stim.txt has a bad record count %0d", n_rec);
         $display("TESTS FAILED");
         $fatal(1, "no usable stimulus");
      end
      timeout_limit = 2 * (n_rec + 3) + 20;

      // Reset for 2 cycles, strobes checked while held
      repeat (2) begin
         @(negedge clk);
         check_outputs();
      end
      rst_n = 1'b1;

      for (int i = 0; i < n_rec; i++) begin
         // One LFSR bit per line picks an idle gap
         lfsr = lfsr_step(lfsr);
         if (lfsr[0]) begin
            @(negedge clk);
            check_outputs();
            drive_idle();
         end
         @(negedge clk);
         check_outputs();
         drive_line(i);
      end

      // Drain the pipe
      while (exp_q.size() != 0) begin
         @(negedge clk);
         check_outputs();
         drive_idle();
      end

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: bru_top.sv
// Branch path top chaining decode, execute and result stages
`timescale 1ns/1ns

module bru_top #(
   parameter int CONFIG_DW = 32,
   parameter int CONFIG_AW = 32,
   localparam int PC_W = CONFIG_AW - bru_pkg::P_INSN_LEN
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_valid,
   input  bru_pkg::insn_t        in_insn,
   input  logic [PC_W-1:0]       in_pc,
   input  logic [CONFIG_DW-1:0]  in_operand1,
   input  logic [CONFIG_DW-1:0]  in_operand2,
   output logic                  br_valid,
   output logic                  br_taken,
   output logic [PC_W-1:0]       br_tgt,
   output logic                  lnk_we,
   output logic [CONFIG_DW-1:0]  lnk_data,
   output logic                  align_fault
);

   // Decode to execute
   logic                 dec_valid;
   bru_pkg::bru_opc_t    dec_opc;
   logic [CONFIG_DW-1:0] dec_imm;
   logic                 dec_rf_we;
   logic [PC_W-1:0]      dec_pc;
   logic [CONFIG_DW-1:0] dec_operand1;
   logic [CONFIG_DW-1:0] dec_operand2;

   // Execute to result
   logic                           ex_valid_q;
   logic                           b_taken;
   logic [PC_W-1:0]                b_tgt;
   logic                           b_lnk;
   logic                           is_bcc;
   logic                           is_breg;
   logic                           is_brel;
   logic [PC_W-1:0]                ex_pc_q;
   logic [bru_pkg::P_INSN_LEN-1:0] ex_operand1_low;

   bru_decode #(
      .CONFIG_DW (CONFIG_DW),
      .PC_W      (PC_W)
   ) i_decode (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_insn      (in_insn),
      .in_pc        (in_pc),
      .in_operand1  (in_operand1),
      .in_operand2  (in_operand2),
      .dec_valid    (dec_valid),
      .dec_opc      (dec_opc),
      .dec_imm      (dec_imm),
      .dec_rf_we    (dec_rf_we),
      .dec_pc       (dec_pc),
      .dec_operand1 (dec_operand1),
      .dec_operand2 (dec_operand2)
   );

   bru_execute #(
      .CONFIG_DW (CONFIG_DW),
      .CONFIG_AW (CONFIG_AW),
      .PC_W      (PC_W)
   ) i_execute (
      .clk             (clk),
      .rst_n           (rst_n),
      .dec_valid       (dec_valid),
      .dec_opc         (dec_opc),
      .dec_imm         (dec_imm),
      .dec_rf_we       (dec_rf_we),
      .dec_pc          (dec_pc),
      .dec_operand1    (dec_operand1),
      .dec_operand2    (dec_operand2),
      .ex_valid_q      (ex_valid_q),
      .b_taken         (b_taken),
      .b_tgt           (b_tgt),
      .b_lnk           (b_lnk),
      .is_bcc          (is_bcc),
      .is_breg         (is_breg),
      .is_brel         (is_brel),
      .ex_pc_q         (ex_pc_q),
      .ex_operand1_low (ex_operand1_low)
   );

   bru_result #(
      .CONFIG_DW (CONFIG_DW),
      .PC_W      (PC_W)
   ) i_result (
      .clk             (clk),
      .rst_n           (rst_n),
      .ex_valid_q      (ex_valid_q),
      .b_taken         (b_taken),
      .b_tgt           (b_tgt),
      .b_lnk           (b_lnk),
      .is_bcc          (is_bcc),
      .is_breg         (is_breg),
      .is_brel         (is_brel),
      .ex_pc_q         (ex_pc_q),
      .ex_operand1_low (ex_operand1_low),
      .br_valid        (br_valid),
      .br_taken        (br_taken),
      .br_tgt          (br_tgt),
      .lnk_we          (lnk_we),
      .lnk_data        (lnk_data),
      .align_fault     (align_fault)
   );

endmodule

// File: bru_result.sv
// Branch result stage with redirect, link address and register jump alignment check
`timescale 1ns/1ns

module bru_result #(
   parameter int CONFIG_DW = 32,
   parameter int PC_W = 30
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          ex_valid_q,
   input  logic                          b_taken,
   input  logic [PC_W-1:0]               b_tgt,
   input  logic                          b_lnk,
   input  logic                          is_bcc,
   input  logic                          is_breg,
   input  logic                          is_brel,
   input  logic [PC_W-1:0]               ex_pc_q,
   input  logic [bru_pkg::P_INSN_LEN-1:0] ex_operand1_low,
   output logic                          br_valid,
   output logic                          br_taken,
   output logic [PC_W-1:0]               br_tgt,
   output logic                          lnk_we,
   output logic [CONFIG_DW-1:0]          lnk_data,
   output logic                          align_fault
);

   logic            fault;
   logic            taken_ok;
   logic [PC_W-1:0] pc_next;

   // Register jump target must be instruction aligned
   assign fault = ex_valid_q & is_breg & (|ex_operand1_low);

   // Fault cancels the redirect
   assign taken_ok = b_taken & ~fault;

   // Return address in instruction units
   assign pc_next = ex_pc_q + PC_W'(1);

   // Strobes
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         br_valid <= 1'b0;
         br_taken <= 1'b0;
         lnk_we <= 1'b0;
         align_fault <= 1'b0;
      end else begin
         br_valid <= ex_valid_q & (is_bcc | is_breg | is_brel);
         br_taken <= taken_ok;
         // No link write on a faulting jump
         lnk_we <= ex_valid_q & b_lnk & ~fault;
         align_fault <= fault;
      end
   end

   // Target and link data
   always_ff @(posedge clk) begin
      br_tgt <= taken_ok ? b_tgt : '0;
      // Byte address of the next instruction
      lnk_data <= CONFIG_DW'({pc_next, {bru_pkg::P_INSN_LEN{1'b0}}});
   end

   // Redirect only from a valid branch or jump
   assert property (@(posedge clk) disable iff (!rst_n)
      b_taken |-> (ex_valid_q && (is_bcc || is_breg || is_brel)))
      else $error("bru_result: taken without a valid branch class");

endmodule

// File: bru_execute.sv
// Branch execute stage with compare subtraction and registered branch unit result
`timescale 1ns/1ns

module bru_execute #(
   parameter int CONFIG_DW = 32,
   parameter int CONFIG_AW = 32,
   parameter int PC_W = 30
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          dec_valid,
   input  bru_pkg::bru_opc_t             dec_opc,
   input  logic [CONFIG_DW-1:0]          dec_imm,
   input  logic                          dec_rf_we,
   input  logic [PC_W-1:0]               dec_pc,
   input  logic [CONFIG_DW-1:0]          dec_operand1,
   input  logic [CONFIG_DW-1:0]          dec_operand2,
   output logic                          ex_valid_q,
   output logic                          b_taken,
   output logic [PC_W-1:0]               b_tgt,
   output logic                          b_lnk,
   output logic                          is_bcc,
   output logic                          is_breg,
   output logic                          is_brel,
   output logic [PC_W-1:0]               ex_pc_q,
   output logic [bru_pkg::P_INSN_LEN-1:0] ex_operand1_low
);

   logic [CONFIG_DW-1:0] add_sum;
   logic                 add_carry;
   logic                 add_overflow;
   logic                 bru_taken;
   logic [PC_W-1:0]      bru_tgt;
   logic                 bru_lnk;
   logic                 bru_bcc;
   logic                 bru_breg;
   logic                 bru_brel;

   // operand1 + ~operand2 + 1, carry out set means no borrow
   assign {add_carry, add_sum} = {1'b0, dec_operand1} + {1'b0, ~dec_operand2} +
                                 (CONFIG_DW+1)'(1);

   // Overflow when signs differ and result sign flips from operand1
   assign add_overflow = (dec_operand1[CONFIG_DW-1] ^ dec_operand2[CONFIG_DW-1]) &
                         (add_sum[CONFIG_DW-1] ^ dec_operand1[CONFIG_DW-1]);

   ex_bru #(
      .CONFIG_DW (CONFIG_DW),
      .CONFIG_AW (CONFIG_AW),
      .PC_W      (PC_W)
   ) i_ex_bru (
      .ex_valid       (dec_valid),
      .ex_bru_opc_bus (dec_opc),
      .ex_pc          (dec_pc),
      .ex_imm         (dec_imm),
      .ex_operand1    (dec_operand1),
      .ex_operand2    (dec_operand2),
      .ex_rf_we       (dec_rf_we),
      .add_sum        (add_sum),
      .add_carry      (add_carry),
      .add_overflow   (add_overflow),
      .b_taken        (bru_taken),
      .b_tgt          (bru_tgt),
      .b_lnk          (bru_lnk),
      .is_bcc         (bru_bcc),
      .is_breg        (bru_breg),
      .is_brel        (bru_brel)
   );

   // Control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid_q <= 1'b0;
         b_taken <= 1'b0;
      end else begin
         ex_valid_q <= dec_valid;
         b_taken <= bru_taken;
      end
   end

   // Payload
   always_ff @(posedge clk) begin
      b_tgt <= bru_tgt;
      b_lnk <= bru_lnk;
      is_bcc <= bru_bcc;
      is_breg <= bru_breg;
      is_brel <= bru_brel;
      ex_pc_q <= dec_pc;
      // Kept for the alignment check downstream
      ex_operand1_low <= dec_operand1[bru_pkg::P_INSN_LEN-1:0];
   end

   // A taken branch must belong to a valid instruction
   assert property (@(posedge clk) disable iff (!rst_n)
      b_taken |-> ex_valid_q)
      else $error("bru_execute: taken branch without valid");

endmodule

// File: ex_bru.sv
// Branch unit resolving conditions from the subtraction flags and selecting the target
`timescale 1ns/1ns

module ex_bru #(
   parameter int CONFIG_DW = 32,
   parameter int CONFIG_AW = 32,
   parameter int PC_W = 30
) (
   input  logic                  ex_valid,
   input  bru_pkg::bru_opc_t     ex_bru_opc_bus,
   input  logic [PC_W-1:0]       ex_pc,
   input  logic [CONFIG_DW-1:0]  ex_imm,
   input  logic [CONFIG_DW-1:0]  ex_operand1,
   input  logic [CONFIG_DW-1:0]  ex_operand2,
   input  logic                  ex_rf_we,
   // Flags of operand1 minus operand2
   input  logic [CONFIG_DW-1:0]  add_sum,
   input  logic                  add_carry,
   input  logic                  add_overflow,
   output logic                  b_taken,
   output logic [PC_W-1:0]       b_tgt,
   output logic                  b_lnk,
   output logic                  is_bcc,
   output logic                  is_breg,
   output logic                  is_brel
);

   logic cmp_eq;
   logic cmp_gt_s;
   logic cmp_gt_u;
   logic bcc_taken;
   logic is_jmp;

   // Zero difference means equal
   assign cmp_eq = (add_sum == '0);
   // Signed: result non-negative after overflow correction, and not equal
   assign cmp_gt_s = ~(add_sum[CONFIG_DW-1] ^ add_overflow) & ~cmp_eq;
   // Unsigned: no borrow, and not equal
   assign cmp_gt_u = add_carry & ~cmp_eq;

   // Branch class
   assign is_bcc = |ex_bru_opc_bus[bru_pkg::BRU_BLE:bru_pkg::BRU_BEQ];
   assign is_breg = ex_bru_opc_bus[bru_pkg::BRU_JMPREG];
   assign is_brel = ex_bru_opc_bus[bru_pkg::BRU_JMPREL];
   assign is_jmp = is_breg | is_brel;

   // Six conditions, le is the complement of gt
   assign bcc_taken = (ex_bru_opc_bus[bru_pkg::BRU_BEQ] & cmp_eq) |
                      (ex_bru_opc_bus[bru_pkg::BRU_BNE] & ~cmp_eq) |
                      (ex_bru_opc_bus[bru_pkg::BRU_BGTU] & cmp_gt_u) |
                      (ex_bru_opc_bus[bru_pkg::BRU_BGT] & cmp_gt_s) |
                      (ex_bru_opc_bus[bru_pkg::BRU_BLEU] & ~cmp_gt_u) |
                      (ex_bru_opc_bus[bru_pkg::BRU_BLE] & ~cmp_gt_s);

   // Jumps are unconditional
   assign b_taken = ex_valid & (bcc_taken | is_jmp);

   // Target by addressing mode, zero when nothing selected
   assign b_tgt =
      // PC plus offset in instruction units
      ({PC_W{bcc_taken}} & (ex_pc + ex_imm[PC_W-1:0])) |
      // PC plus byte offset from operand2
      ({PC_W{is_brel}} & (ex_pc + ex_operand2[CONFIG_AW-1:bru_pkg::P_INSN_LEN])) |
      // Byte address from operand1
      ({PC_W{is_breg}} & ex_operand1[CONFIG_AW-1:bru_pkg::P_INSN_LEN]);

   // Link only for jumps with the link bit
   assign b_lnk = is_jmp & ex_rf_we;

endmodule

// File: bru_decode.sv
// Branch decode stage turning the instruction word into operation bus, offset and link
`timescale 1ns/1ns

module bru_decode #(
   parameter int CONFIG_DW = 32,
   parameter int PC_W = 30
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_valid,
   input  bru_pkg::insn_t        in_insn,
   input  logic [PC_W-1:0]       in_pc,
   input  logic [CONFIG_DW-1:0]  in_operand1,
   input  logic [CONFIG_DW-1:0]  in_operand2,
   output logic                  dec_valid,
   output bru_pkg::bru_opc_t     dec_opc,
   output logic [CONFIG_DW-1:0]  dec_imm,
   output logic                  dec_rf_we,
   output logic [PC_W-1:0]       dec_pc,
   output logic [CONFIG_DW-1:0]  dec_operand1,
   output logic [CONFIG_DW-1:0]  dec_operand2
);

   bru_pkg::opcode_t  opc;
   bru_pkg::offs_t    offs;
   bru_pkg::bru_opc_t opc_bus;
   logic [CONFIG_DW-1:0] imm_ext;

   // Field extraction
   assign opc = in_insn[bru_pkg::OPC_LSB +: bru_pkg::OPC_W];
   assign offs = in_insn[bru_pkg::OFFS_LSB +: bru_pkg::OFFS_W];

   // Sign extend offset to data width
   assign imm_ext = {{(CONFIG_DW-bru_pkg::OFFS_W){offs[bru_pkg::OFFS_W-1]}}, offs};

   // Opcode to one-hot bus
   always_comb begin
      opc_bus = '0;
      case (opc)
         bru_pkg::OPC_BEQ:    opc_bus[bru_pkg::BRU_BEQ] = 1'b1;
         bru_pkg::OPC_BNE:    opc_bus[bru_pkg::BRU_BNE] = 1'b1;
         bru_pkg::OPC_BGTU:   opc_bus[bru_pkg::BRU_BGTU] = 1'b1;
         bru_pkg::OPC_BGT:    opc_bus[bru_pkg::BRU_BGT] = 1'b1;
         bru_pkg::OPC_BLEU:   opc_bus[bru_pkg::BRU_BLEU] = 1'b1;
         bru_pkg::OPC_BLE:    opc_bus[bru_pkg::BRU_BLE] = 1'b1;
         bru_pkg::OPC_JMPREL: opc_bus[bru_pkg::BRU_JMPREL] = 1'b1;
         bru_pkg::OPC_JMPREG: opc_bus[bru_pkg::BRU_JMPREG] = 1'b1;
         // Non-branch leaves the bus empty
         default:             opc_bus = '0;
      endcase
   end

   // Valid strobe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= in_valid;
      end
   end

   // Payload, sampled every cycle
   always_ff @(posedge clk) begin
      dec_opc <= opc_bus;
      dec_imm <= imm_ext;
      dec_rf_we <= in_insn[bru_pkg::LNK_BIT];
      dec_pc <= in_pc;
      dec_operand1 <= in_operand1;
      dec_operand2 <= in_operand2;
   end

   // A valid instruction must carry a known word
   assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> !$isunknown(in_insn))
      else $error("bru_decode: unknown instruction word with valid");

endmodule

// File: bru_pkg.sv
// Branch unit package with instruction fields, opcodes, operation bus bits and types
package bru_pkg;

   // Log2 of instruction size in bytes
   localparam int P_INSN_LEN = 2;

   // Instruction word and its fields
   typedef logic [31:0] insn_t;

   localparam int OPC_LSB = 0;
   localparam int OPC_W = 4;
   // Link enable bit
   localparam int LNK_BIT = 4;
   // Branch offset field, top of the word
   localparam int OFFS_LSB = 17;
   localparam int OFFS_W = 15;

   typedef logic [OPC_W-1:0] opcode_t;
   typedef logic [OFFS_W-1:0] offs_t;

   // Branch opcodes
   // Zero and all unlisted codes are non-branch
   localparam opcode_t OPC_BEQ = 4'h1;
   localparam opcode_t OPC_BNE = 4'h2;
   localparam opcode_t OPC_BGTU = 4'h3;
   localparam opcode_t OPC_BGT = 4'h4;
   localparam opcode_t OPC_BLEU = 4'h5;
   localparam opcode_t OPC_BLE = 4'h6;
   localparam opcode_t OPC_JMPREL = 4'h7;
   localparam opcode_t OPC_JMPREG = 4'h8;

   // One-hot operation bus
   localparam int BRU_IOPW = 8;

   typedef logic [BRU_IOPW-1:0] bru_opc_t;

   // Bit positions in the operation bus
   localparam int BRU_BEQ = 0;
   localparam int BRU_BNE = 1;
   localparam int BRU_BGTU = 2;
   localparam int BRU_BGT = 3;
   localparam int BRU_BLEU = 4;
   localparam int BRU_BLE = 5;
   localparam int BRU_JMPREL = 6;
   localparam int BRU_JMPREG = 7;

endpackage
